// ==== sim/debug_props.sv ====
`timescale 1ns/1ps

module debug_props (
    input logic                         i_clock,
    input logic                         i_arst_n,
    input logic                         req,
    input logic                         ack,
    input logic [debug_pkg::ADDR_W-1:0] addr,
    input logic                         tx_start,
    input logic                         tx_done
);

    logic tx_pending;

    // a byte is in flight from its start pulse until its done pulse
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tx_pending <= 1'b0;
        end else if (tx_start) begin
            tx_pending <= 1'b1;
        end else if (tx_done) begin
            tx_pending <= 1'b0;
        end
    end

    ack_needs_req: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    req_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (req && !ack) |=> req)
        else $error("req dropped before ack");

    addr_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (req && $past(req)) |-> (addr == $past(addr)))
        else $error("addr changed while req was high");

    tx_start_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        tx_start |=> !tx_start)
        else $error("tx_start high on two consecutive cycles");

    tx_one_at_a_time: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        tx_pending |-> !tx_start)
        else $error("tx_start while a byte still awaits tx_done");

endmodule

// read side and tx pacing
bind dump_streamer debug_props u_stream_props (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .req      (rd.req),
    .ack      (rd.ack),
    .addr     (rd.addr),
    .tx_start (o_tx_start),
    .tx_done  (i_tx_done)
);

// write side, no tx traffic here
bind debug_mem debug_props u_wr_props (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .req      (wr.req),
    .ack      (wr.ack),
    .addr     (wr.addr),
    .tx_start (1'b0),
    .tx_done  (1'b0)
);

// ==== sim/tb_debug_top.sv ====
`timescale 1ns/1ps

module tb_debug_top;
    import debug_pkg::*;

    // two loads and seven dumps at roughly 20 cycles per byte with margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic              i_clock;
    logic              i_arst_n;
    logic              i_rx_done;
    logic [BYTE_W-1:0] i_rx_data;
    logic              i_tx_done;
    logic              o_tx_start;
    logic [BYTE_W-1:0] o_tx_data;
    parser_state_t     o_state;

    logic [WORD_W-1:0] model_mem [MEM_DEPTH];
    logic [BYTE_W-1:0] tx_q [$];
    logic [BYTE_W-1:0] junk;
    int                cycles = 0;
    int                checks = 0;
    int                errors = 0;
    int                test_start = 0;

    debug_top u_debug_top (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx_done  (i_rx_done),
        .i_rx_data  (i_rx_data),
        .i_tx_done  (i_tx_done),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .o_state    (o_state)
    );

    initial i_clock = 1'b0;
    always #2 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: dump did not complete");
            $display("Test failed");
            $finish;
        end
    end

    // tx model captures each byte and answers with done after 1 to 12 cycles
    always begin
        int unsigned delay;
        @(negedge i_clock);
        if (o_tx_start === 1'b1) begin
            tx_q.push_back(o_tx_data);
            delay = 1 + $urandom_range(11);
            repeat (delay) @(negedge i_clock);
            i_tx_done = 1'b1;
            @(negedge i_clock);
            i_tx_done = 1'b0;
        end
    end

    task automatic send_byte(input logic [BYTE_W-1:0] b);
        int unsigned gap;
        gap = 8 + $urandom_range(12);
        repeat (gap) @(negedge i_clock);
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(negedge i_clock);
        i_rx_done = 1'b0;
    endtask

    task automatic wait_idle();
        while (o_state != ST_IDLE) @(negedge i_clock);
    endtask

    task automatic check_state(input parser_state_t exp);
        checks++;
        assert (o_state == exp) else begin
            $display("CHECK FAILED o_state expected %h got %h", exp, o_state);
            errors++;
        end
    endtask

    task automatic check_byte(input int idx, input logic [BYTE_W-1:0] exp_b,
                              input logic [BYTE_W-1:0] got);
        checks++;
        assert (got === exp_b) else begin
            $display("CHECK FAILED o_tx_data byte %0d expected %h got %h", idx, exp_b, got);
            errors++;
        end
    endtask

    task automatic run_load(input int n);
        logic [WORD_W-1:0] w;
        send_byte(CMD_LOAD);
        send_byte(BYTE_W'(n));
        for (int i = 0; i < n; i++) begin
            w = $urandom;
            model_mem[i] = w;
            for (int b = 0; b < 4; b++) begin
                send_byte(w[8*b +: 8]);
            end
        end
        wait_idle();
    endtask

    // words first and then the checksum of the same words
    task automatic run_dump(input int n);
        logic [WORD_W-1:0] csum;
        logic [BYTE_W-1:0] exp_b;
        int                idx;
        csum = '0;
        tx_q.delete();
        send_byte(CMD_DUMP);
        send_byte(BYTE_W'(n));
        wait_idle();
        checks++;
        assert (tx_q.size() == 4 * n + 4) else begin
            $display("dump of %0d words returned %0d bytes instead of %0d",
                     n, tx_q.size(), 4 * n + 4);
            errors++;
        end
        for (int i = 0; i <= n; i++) begin
            for (int b = 0; b < 4; b++) begin
                idx = 4 * i + b;
                exp_b = (i < n) ? model_mem[i][8*b +: 8] : csum[8*b +: 8];
                if (idx < tx_q.size()) begin
                    check_byte(idx, exp_b, tx_q[idx]);
                end
            end
            if (i < n) begin
                csum = csum ^ model_mem[i];
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        i_arst_n  = 1'b0;
        i_rx_done = 1'b0;
        i_rx_data = '0;
        i_tx_done = 1'b0;
        void'($urandom(53135));
        repeat (16) @(negedge i_clock);
        i_arst_n = 1'b1;

        check_state(ST_IDLE);
        repeat (50) @(negedge i_clock);
        checks++;
        assert (tx_q.size() == 0) else begin
            $display("o_tx_start pulsed while idle after reset");
            errors++;
        end
        end_test("reset idle");

        run_load(32);
        run_dump(32);
        end_test("full load and dump");

        run_load(1 + $urandom_range(7));
        run_dump(32);
        end_test("partial load");

        tx_q.delete();
        do begin
            junk = $urandom;
        end while (junk == CMD_LOAD || junk == CMD_DUMP);
        send_byte(junk);
        check_state(ST_IDLE);
        send_byte(CMD_LOAD);
        send_byte(8'd0);
        check_state(ST_IDLE);
        send_byte(CMD_LOAD);
        send_byte(8'd40);
        check_state(ST_IDLE);
        send_byte(CMD_DUMP);
        send_byte(8'd40);
        check_state(ST_IDLE);
        repeat (20) @(negedge i_clock);
        checks++;
        assert (tx_q.size() == 0) else begin
            $display("bad dump count still produced tx bytes");
            errors++;
        end
        run_dump(32);
        end_test("bad commands");

        repeat (4) run_dump(1 + $urandom_range(31));
        end_test("random dumps");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/debug_pkg.sv
verilog/mem_ports_if.sv
verilog/cmd_parser.sv
verilog/debug_mem.sv
verilog/dump_streamer.sv
verilog/debug_top.sv
sim/debug_props.sv
sim/tb_debug_top.sv

// ==== verilog/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
    input  logic                         i_clock,
    input  logic                         i_arst_n,
    input  logic                         i_rx_done,
    input  logic [debug_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                         i_busy,
    mem_wr_if.producer                   wr,
    output logic                         o_dump_start,
    output logic [debug_pkg::CNT_W-1:0]  o_dump_count,
    output debug_pkg::parser_state_t     o_state
);
    import debug_pkg::*;

    parser_state_t     state_q;
    logic [CNT_W-1:0]  count_q;
    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        byte_idx_q;
    logic [WORD_W-1:0] word_q;
    logic              req_q;
    logic              start_q;
    logic              rx_ok;
    logic              count_ok;
    logic              last_word;

    // bytes arriving during a dump are dropped here
    assign rx_ok = i_rx_done && !i_busy;

    // valid counts are 1 to MEM_DEPTH
    assign count_ok = (i_rx_data != '0) && (i_rx_data <= BYTE_W'(MEM_DEPTH));

    assign last_word = (CNT_W'(addr_q) + CNT_W'(1)) == count_q;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= ST_IDLE;
            count_q    <= '0;
            addr_q     <= '0;
            byte_idx_q <= '0;
            req_q      <= 1'b0;
            start_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (rx_ok) begin
                        if (i_rx_data == CMD_LOAD) begin
                            state_q <= ST_LOAD_COUNT;
                        end else if (i_rx_data == CMD_DUMP) begin
                            state_q <= ST_DUMP_COUNT;
                        end
                    end
                end
                ST_LOAD_COUNT: begin
                    if (rx_ok) begin
                        if (count_ok) begin
                            count_q    <= i_rx_data[CNT_W-1:0];
                            addr_q     <= '0;
                            byte_idx_q <= '0;
                            state_q    <= ST_LOAD_DATA;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_LOAD_DATA: begin
                    if (rx_ok) begin
                        byte_idx_q <= byte_idx_q + 2'd1;
                        if (byte_idx_q == 2'd3) begin
                            req_q   <= 1'b1;
                            state_q <= ST_LOAD_WRITE;
                        end
                    end
                end
                ST_LOAD_WRITE: begin
                    // drop req on ack, move on once ack is low again
                    if (req_q && wr.ack) begin
                        req_q <= 1'b0;
                    end else if (!req_q && !wr.ack) begin
                        if (last_word) begin
                            state_q <= ST_IDLE;
                        end else begin
                            addr_q  <= addr_q + ADDR_W'(1);
                            state_q <= ST_LOAD_DATA;
                        end
                    end
                end
                ST_DUMP_COUNT: begin
                    if (rx_ok) begin
                        if (count_ok) begin
                            count_q <= i_rx_data[CNT_W-1:0];
                            start_q <= 1'b1;
                            state_q <= ST_DUMP_WAIT;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_DUMP_WAIT: begin
                    // busy rises the cycle after the start pulse
                    if (!start_q && !i_busy) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // word assembly, first byte lands in the low lane
    always_ff @(posedge i_clock) begin
        if (state_q == ST_LOAD_DATA && rx_ok) begin
            word_q <= {i_rx_data, word_q[WORD_W-1:BYTE_W]};
        end
    end

    assign wr.req       = req_q;
    assign wr.addr      = addr_q;
    assign wr.wdata     = word_q;
    assign o_dump_start = start_q;
    assign o_dump_count = count_q;
    assign o_state      = state_q;

endmodule

// ==== verilog/debug_mem.sv ====
`timescale 1ns/1ps

module debug_mem (
    input  logic      i_clock,
    input  logic      i_arst_n,
    mem_wr_if.memory  wr,
    mem_rd_if.memory  rd
);
    import debug_pkg::*;

    logic [WORD_W-1:0] mem_q [MEM_DEPTH];
    logic [WORD_W-1:0] rdata_q;
    logic              wr_ack_q;
    logic              rd_ack_q;
    logic              wr_go;
    logic              rd_go;

    // one access per cycle, write wins
    assign wr_go = wr.req && !wr_ack_q;
    assign rd_go = rd.req && !rd_ack_q && !wr_go;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ack_q <= 1'b0;
            rd_ack_q <= 1'b0;
        end else begin
            if (wr_go) begin
                wr_ack_q <= 1'b1;
            end else if (!wr.req) begin
                wr_ack_q <= 1'b0;
            end

            if (rd_go) begin
                rd_ack_q <= 1'b1;
            end else if (!rd.req) begin
                rd_ack_q <= 1'b0;
            end
        end
    end

    // storage and read register
    always_ff @(posedge i_clock) begin
        if (wr_go) begin
            mem_q[wr.addr] <= wr.wdata;
        end
        if (rd_go) begin
            rdata_q <= mem_q[rd.addr];
        end
    end

    assign wr.ack   = wr_ack_q;
    assign rd.ack   = rd_ack_q;
    // held until the next read access
    assign rd.rdata = rdata_q;

endmodule

// ==== verilog/debug_pkg.sv ====
package debug_pkg;

    // data widths
    localparam int BYTE_W = 8;
    localparam int WORD_W = 32;

    // debug memory geometry
    localparam int MEM_DEPTH = 32;
    localparam int ADDR_W = 5;

    // word count, wide enough to hold MEM_DEPTH itself
    localparam int CNT_W = 6;

    // host command bytes, ascii 'L' and 'D'
    localparam logic [BYTE_W-1:0] CMD_LOAD = 8'h4C;
    localparam logic [BYTE_W-1:0] CMD_DUMP = 8'h44;

    // parser FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_COUNT,
        ST_LOAD_DATA,
        ST_LOAD_WRITE,
        ST_DUMP_COUNT,
        ST_DUMP_WAIT
    } parser_state_t;

endpackage

// ==== verilog/debug_top.sv ====
`timescale 1ns/1ps

module debug_top (
    input  logic                         i_clock,
    input  logic                         i_arst_n,
    input  logic                         i_rx_done,
    input  logic [debug_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                         i_tx_done,
    output logic                         o_tx_start,
    output logic [debug_pkg::BYTE_W-1:0] o_tx_data,
    output debug_pkg::parser_state_t     o_state
);
    import debug_pkg::*;

    logic             dump_start;
    logic [CNT_W-1:0] dump_count;
    logic             busy;

    mem_wr_if wr_bus ();
    mem_rd_if rd_bus ();

    cmd_parser u_cmd_parser (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .i_busy       (busy),
        .wr           (wr_bus.producer),
        .o_dump_start (dump_start),
        .o_dump_count (dump_count),
        .o_state      (o_state)
    );

    debug_mem u_debug_mem (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .wr       (wr_bus.memory),
        .rd       (rd_bus.memory)
    );

    dump_streamer u_dump_streamer (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_dump_start (dump_start),
        .i_dump_count (dump_count),
        .rd           (rd_bus.consumer),
        .i_tx_done    (i_tx_done),
        .o_tx_start   (o_tx_start),
        .o_tx_data    (o_tx_data),
        .o_busy       (busy)
    );

endmodule

// ==== verilog/dump_streamer.sv ====
`timescale 1ns/1ps

module dump_streamer (
    input  logic                         i_clock,
    input  logic                         i_arst_n,
    input  logic                         i_dump_start,
    input  logic [debug_pkg::CNT_W-1:0]  i_dump_count,
    mem_rd_if.consumer                   rd,
    input  logic                         i_tx_done,
    output logic                         o_tx_start,
    output logic [debug_pkg::BYTE_W-1:0] o_tx_data,
    output logic                         o_busy
);
    import debug_pkg::*;

    typedef enum logic [2:0] {
        SS_IDLE,
        SS_READ,
        SS_RELEASE,
        SS_BYTE,
        SS_TX_WAIT
    } stream_state_t;

    stream_state_t     state_q;
    logic [CNT_W-1:0]  count_q;
    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        byte_idx_q;
    logic              sum_phase_q;
    logic              req_q;
    logic              tx_start_q;
    logic [WORD_W-1:0] word_q;
    logic [WORD_W-1:0] csum_q;
    logic [BYTE_W-1:0] tx_data_q;
    logic              last_word;
    logic              word_done;

    assign last_word = (CNT_W'(addr_q) + CNT_W'(1)) == count_q;
    assign word_done = (state_q == SS_TX_WAIT) && i_tx_done && (byte_idx_q == 2'd3);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= SS_IDLE;
            count_q     <= '0;
            addr_q      <= '0;
            byte_idx_q  <= '0;
            sum_phase_q <= 1'b0;
            req_q       <= 1'b0;
            tx_start_q  <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;
            case (state_q)
                SS_IDLE: begin
                    if (i_dump_start) begin
                        count_q     <= i_dump_count;
                        addr_q      <= '0;
                        sum_phase_q <= 1'b0;
                        req_q       <= 1'b1;
                        state_q     <= SS_READ;
                    end
                end
                SS_READ: begin
                    if (rd.ack) begin
                        req_q   <= 1'b0;
                        state_q <= SS_RELEASE;
                    end
                end
                SS_RELEASE: begin
                    // wait for ack to fall before sending
                    if (!rd.ack) begin
                        byte_idx_q <= '0;
                        state_q    <= SS_BYTE;
                    end
                end
                SS_BYTE: begin
                    tx_start_q <= 1'b1;
                    state_q    <= SS_TX_WAIT;
                end
                SS_TX_WAIT: begin
                    if (i_tx_done) begin
                        byte_idx_q <= byte_idx_q + 2'd1;
                        if (byte_idx_q != 2'd3) begin
                            state_q <= SS_BYTE;
                        end else if (sum_phase_q) begin
                            state_q <= SS_IDLE;
                        end else if (last_word) begin
                            sum_phase_q <= 1'b1;
                            state_q     <= SS_BYTE;
                        end else begin
                            addr_q  <= addr_q + ADDR_W'(1);
                            req_q   <= 1'b1;
                            state_q <= SS_READ;
                        end
                    end
                end
                default: begin
                    state_q <= SS_IDLE;
                end
            endcase
        end
    end

    // shift register and running checksum
    always_ff @(posedge i_clock) begin
        if (state_q == SS_IDLE && i_dump_start) begin
            csum_q <= '0;
        end
        if (state_q == SS_READ && rd.ack) begin
            word_q <= rd.rdata;
            csum_q <= csum_q ^ rd.rdata;
        end else if (word_done && !sum_phase_q && last_word) begin
            word_q <= csum_q;
        end else if (state_q == SS_TX_WAIT && i_tx_done) begin
            word_q <= word_q >> BYTE_W;
        end
        if (state_q == SS_BYTE) begin
            tx_data_q <= word_q[BYTE_W-1:0];
        end
    end

    assign rd.req     = req_q;
    assign rd.addr    = addr_q;
    assign o_tx_start = tx_start_q;
    assign o_tx_data  = tx_data_q;
    assign o_busy     = state_q != SS_IDLE;

endmodule

// ==== verilog/mem_ports_if.sv ====
`timescale 1ns/1ps

// write port of the debug memory
interface mem_wr_if;
    import debug_pkg::*;

    logic              req;
    logic              ack;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;

    modport producer (output req, output addr, output wdata, input ack);
    modport memory   (input req, input addr, input wdata, output ack);
endinterface

// read port of the debug memory
interface mem_rd_if;
    import debug_pkg::*;

    logic              req;
    logic              ack;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] rdata;

    modport consumer (output req, output addr, input ack, input rdata);
    modport memory   (input req, input addr, output ack, output rdata);
endinterface
